//--- bench/csrCoreChecker.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrCoreChecker (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   expPush,
  input  logic                   expRetire,
  input  logic [`REG_ADDR_W-1:0] expRd,
  input  logic [`XLEN-1:0]       expData,
  input  logic                   expRedirect,
  input  logic [`XLEN-1:0]       expRedirectPc,
  input  logic                   retireValid,
  input  logic [`REG_ADDR_W-1:0] retireRd,
  input  logic [`XLEN-1:0]       retireData,
  input  logic                   redirectValid,
  input  logic [`XLEN-1:0]       redirectPc,
  output logic [15:0]            rowsChecked,
  output logic [15:0]            rowsFailed,
  output logic [15:0]            strayCount
);

  logic qRet [$];
  logic [`REG_ADDR_W-1:0] qRd [$];
  logic [`XLEN-1:0] qData [$];
  logic qRedir [$];
  logic [`XLEN-1:0] qRedirPc [$];
  int qDue [$];
  int cycle;

  task automatic checkRow();
    logic eRet;
    logic [`REG_ADDR_W-1:0] eRd;
    logic [`XLEN-1:0] eData;
    logic eRedir;
    logic [`XLEN-1:0] ePc;
    logic rowOk;
    eRet = qRet.pop_front();
    eRd = qRd.pop_front();
    eData = qData.pop_front();
    eRedir = qRedir.pop_front();
    ePc = qRedirPc.pop_front();
    void'(qDue.pop_front());
    rowOk = 1'b1;
    if (eRet !== retireValid) begin
      $display("row %0d at %0t: retire strobe %s", rowsChecked, $time,
               eRet ? "did not arrive" : "arrived unexpectedly");
      rowOk = 1'b0;
    end else if (eRet) begin
      if (retireRd !== eRd) begin
        $display("error t=%0t retireRd expected %0d got %0d", $time, eRd, retireRd);
        rowOk = 1'b0;
      end
      if (retireData !== eData) begin
        $display("error t=%0t retireData expected %h got %h", $time, eData, retireData);
        rowOk = 1'b0;
      end
    end
    if (eRedir !== redirectValid) begin
      $display("row %0d at %0t: redirect strobe %s", rowsChecked, $time,
               eRedir ? "did not arrive" : "arrived unexpectedly");
      rowOk = 1'b0;
    end else if (eRedir && (redirectPc !== ePc)) begin
      $display("error t=%0t redirectPc expected %h got %h", $time, ePc, redirectPc);
      rowOk = 1'b0;
    end
    if (rowOk) begin
      $display("row %0d ok at %0t", rowsChecked, $time);
    end else begin
      $display("row %0d wrong at %0t", rowsChecked, $time);
      rowsFailed = rowsFailed + 1;
    end
    rowsChecked = rowsChecked + 1;
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rstN) begin
      cycle = 0;
      rowsChecked = '0;
      rowsFailed = '0;
      strayCount = '0;
    end else begin
      cycle = cycle + 1;
      if ((qDue.size() > 0) && (qDue[0] == cycle)) begin
        checkRow();
      end else if ((retireValid === 1'b1) || (redirectValid === 1'b1)) begin
        $display("stray strobe at %0t with no instruction due", $time);
        strayCount = strayCount + 1;
      end
      // result shows one cycle after the issue is seen here
      if (expPush) begin
        qRet.push_back(expRetire);
        qRd.push_back(expRd);
        qData.push_back(expData);
        qRedir.push_back(expRedirect);
        qRedirPc.push_back(expRedirectPc);
        qDue.push_back(cycle + 1);
      end
    end
  end

endmodule

//--- bench/csrCoreTb.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrCoreTb;

  localparam logic [11:0] mstatusAddr = 12'h300;
  localparam logic [11:0] mtvecAddr = 12'h305;
  localparam logic [11:0] mepcAddr = 12'h341;
  localparam logic [11:0] mcauseAddr = 12'h342;
  localparam logic [11:0] unknownAddr = 12'h7c0;

  logic clk = 1'b0;
  logic rstN;
  logic instrValid;
  logic [31:0] instr;
  logic [`XLEN-1:0] pc;
  logic retireValid;
  logic [`REG_ADDR_W-1:0] retireRd;
  logic [`XLEN-1:0] retireData;
  logic redirectValid;
  logic [`XLEN-1:0] redirectPc;
  logic expPush;
  logic expRetire;
  logic [`REG_ADDR_W-1:0] expRd;
  logic [`XLEN-1:0] expData;
  logic expRedirect;
  logic [`XLEN-1:0] expRedirectPc;
  logic [15:0] rowsChecked;
  logic [15:0] rowsFailed;
  logic [15:0] strayCount;

  logic [31:0] tabInstr [64];
  logic [`XLEN-1:0] tabPc [64];
  logic tabRet [64];
  logic [`REG_ADDR_W-1:0] tabRd [64];
  logic [`XLEN-1:0] tabData [64];
  logic tabRedir [64];
  logic [`XLEN-1:0] tabRedirPc [64];
  int tabGap [64];
  int numRows = 0;
  int cycleCount = 0;
  int cycleLimit;

  always #20 clk = ~clk;

  csrCore i_csrCore (
    .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .pc(pc),
    .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData),
    .redirectValid(redirectValid), .redirectPc(redirectPc)
  );

  csrCoreChecker resultCheck (
    .clk(clk), .rstN(rstN), .expPush(expPush), .expRetire(expRetire), .expRd(expRd),
    .expData(expData), .expRedirect(expRedirect), .expRedirectPc(expRedirectPc),
    .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData),
    .redirectValid(redirectValid), .redirectPc(redirectPc),
    .rowsChecked(rowsChecked), .rowsFailed(rowsFailed), .strayCount(strayCount)
  );

  function automatic logic [31:0] encodeAddi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] encodeCsr(input logic [2:0] funct3, input logic [4:0] rd,
                                            input logic [11:0] csr, input logic [4:0] rs1);
    return {csr, rs1, funct3, rd, 7'b1110011};
  endfunction

  // pc steps by 4 per row from 0x1000
  task automatic addRow(input logic [31:0] ins, input logic ret, input logic [4:0] rd,
                        input logic [63:0] data, input logic redir,
                        input logic [63:0] redirPc, input int gap);
    tabInstr[numRows] = ins;
    tabPc[numRows] = 64'h1000 + 4 * numRows;
    tabRet[numRows] = ret;
    tabRd[numRows] = rd;
    tabData[numRows] = data;
    tabRedir[numRows] = redir;
    tabRedirPc[numRows] = redirPc;
    tabGap[numRows] = gap;
    numRows = numRows + 1;
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout after %0d cycles, %0d of %0d rows checked", cycleCount, rowsChecked,
               numRows);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    pc = '0;
    expPush = 1'b0;
    expRetire = 1'b0;
    expRd = '0;
    expData = '0;
    expRedirect = 1'b0;
    expRedirectPc = '0;

    // addi chain through the bypass, then x0
    addRow(encodeAddi(5'd1, 5'd0, 12'h123), 1'b1, 5'd1, 64'h123, 1'b0, 64'h0, 0);
    addRow(encodeAddi(5'd2, 5'd1, 12'h7ff), 1'b1, 5'd2, 64'h922, 1'b0, 64'h0, 0);
    addRow(encodeAddi(5'd3, 5'd2, 12'hfff), 1'b1, 5'd3, 64'h921, 1'b0, 64'h0, 0);
    addRow(encodeAddi(5'd0, 5'd1, 12'h005), 1'b1, 5'd0, 64'h128, 1'b0, 64'h0, 0);
    addRow(encodeAddi(5'd4, 5'd0, 12'h007), 1'b1, 5'd4, 64'h7, 1'b0, 64'h0, 0);
    addRow(encodeAddi(5'd5, 5'd0, 12'h400), 1'b1, 5'd5, 64'h400, 1'b0, 64'h0, 2);
    // mtvec swap, then read back
    addRow(encodeCsr(3'b001, 5'd6, mtvecAddr, 5'd5), 1'b1, 5'd6, 64'h8000_0100, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd7, mtvecAddr, 5'd0), 1'b1, 5'd7, 64'h400, 1'b0, 64'h0, 0);
    // mepc set and clear
    addRow(encodeCsr(3'b001, 5'd0, mepcAddr, 5'd1), 1'b1, 5'd0, 64'h0, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd9, mepcAddr, 5'd3), 1'b1, 5'd9, 64'h123, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b011, 5'd10, mepcAddr, 5'd4), 1'b1, 5'd10, 64'h923, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd11, mepcAddr, 5'd0), 1'b1, 5'd11, 64'h920, 1'b0, 64'h0, 0);
    // ecall at 0x1030
    addRow(32'h0000_0073, 1'b0, 5'd0, 64'h0, 1'b1, 64'h400, 1);
    addRow(encodeCsr(3'b010, 5'd12, mepcAddr, 5'd0), 1'b1, 5'd12, 64'h1030, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd13, mcauseAddr, 5'd0), 1'b1, 5'd13, 64'd11, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd14, mstatusAddr, 5'd0), 1'b1, 5'd14, 64'h1880, 1'b0, 64'h0, 0);
    // mret, then illegal at 0x1048
    addRow(32'h3020_0073, 1'b0, 5'd0, 64'h0, 1'b1, 64'h1030, 1);
    addRow(encodeCsr(3'b010, 5'd15, mstatusAddr, 5'd0), 1'b1, 5'd15, 64'h1888, 1'b0, 64'h0, 0);
    addRow(32'h0000_0000, 1'b0, 5'd0, 64'h0, 1'b1, 64'h400, 1);
    addRow(encodeCsr(3'b010, 5'd16, mcauseAddr, 5'd0), 1'b1, 5'd16, 64'd2, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd17, mepcAddr, 5'd0), 1'b1, 5'd17, 64'h1048, 1'b0, 64'h0, 0);
    // unimplemented CSR, then all four unchanged
    addRow(encodeCsr(3'b001, 5'd18, unknownAddr, 5'd1), 1'b1, 5'd18, 64'h0, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd19, unknownAddr, 5'd0), 1'b1, 5'd19, 64'h0, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd20, mstatusAddr, 5'd0), 1'b1, 5'd20, 64'h1880, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd21, mtvecAddr, 5'd0), 1'b1, 5'd21, 64'h400, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd22, mepcAddr, 5'd0), 1'b1, 5'd22, 64'h1048, 1'b0, 64'h0, 0);
    addRow(encodeCsr(3'b010, 5'd23, mcauseAddr, 5'd0), 1'b1, 5'd23, 64'd2, 1'b0, 64'h0, 0);
    cycleLimit = 3 * numRows + 5 + 20;

    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < numRows; i++) begin
      @(posedge clk);
      instrValid <= 1'b1;
      instr <= tabInstr[i];
      pc <= tabPc[i];
      expPush <= 1'b1;
      expRetire <= tabRet[i];
      expRd <= tabRd[i];
      expData <= tabData[i];
      expRedirect <= tabRedir[i];
      expRedirectPc <= tabRedirPc[i];
      repeat (tabGap[i]) begin
        @(posedge clk);
        instrValid <= 1'b0;
        expPush <= 1'b0;
      end
    end
    @(posedge clk);
    instrValid <= 1'b0;
    expPush <= 1'b0;

    wait (rowsChecked == numRows);
    repeat (3) @(posedge clk);
    $display("rows %0d, wrong %0d, stray strobes %0d", rowsChecked, rowsFailed, strayCount);
    if ((rowsFailed == 0) && (strayCount == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- csrCore.f
+incdir+logic
logic/csrPkg.sv
logic/regFile.sv
logic/csrFile.sv
logic/instrDecode.sv
logic/csrExecute.sv
logic/csrCore.sv
bench/csrCoreChecker.sv
bench/csrCoreTb.sv

//--- logic/csrCore.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrCore (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic [31:0]            instr,
  input  logic [`XLEN-1:0]       pc,
  output logic                   retireValid,
  output logic [`REG_ADDR_W-1:0] retireRd,
  output logic [`XLEN-1:0]       retireData,
  output logic                   redirectValid,
  output logic [`XLEN-1:0]       redirectPc
);

  logic [`REG_ADDR_W-1:0] r1Addr;
  logic [`XLEN-1:0] r1Data;
  logic [11:0] csrReadAddr;
  logic [`XLEN-1:0] csrReadData;

  // stage two
  logic exValid;
  logic [2:0] exOp;
  logic [`REG_ADDR_W-1:0] exRd;
  logic [`XLEN-1:0] exRs1Val;
  logic [`XLEN-1:0] exImm;
  logic [11:0] exCsrAddr;
  logic [`XLEN-1:0] exCsrOld;
  logic [`XLEN-1:0] exPc;

  // writebacks, also the decode bypass
  logic regWen;
  logic [`REG_ADDR_W-1:0] regAddr;
  logic [`XLEN-1:0] regData;
  logic csrWen;
  logic [11:0] csrWriteAddr;
  logic [`XLEN-1:0] csrWriteData;

  logic trapEnter;
  logic [`XLEN-1:0] trapCause;
  logic [`XLEN-1:0] trapPc;
  logic trapReturn;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;

  instrDecode i_instrDecode (
    .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .pc(pc),
    .r1Addr(r1Addr), .r1Data(r1Data), .csrReadAddr(csrReadAddr), .csrReadData(csrReadData),
    .fwdRegWen(regWen), .fwdRegAddr(regAddr), .fwdRegData(regData),
    .fwdCsrWen(csrWen), .fwdCsrAddr(csrWriteAddr), .fwdCsrData(csrWriteData),
    .exValid(exValid), .exOp(exOp), .exRd(exRd), .exRs1Val(exRs1Val), .exImm(exImm),
    .exCsrAddr(exCsrAddr), .exCsrOld(exCsrOld), .exPc(exPc)
  );

  csrExecute i_csrExecute (
    .exValid(exValid), .exOp(exOp), .exRd(exRd), .exRs1Val(exRs1Val), .exImm(exImm),
    .exCsrAddr(exCsrAddr), .exCsrOld(exCsrOld), .exPc(exPc), .mtvec(mtvec), .mepc(mepc),
    .regWen(regWen), .regAddr(regAddr), .regData(regData),
    .csrWen(csrWen), .csrWriteAddr(csrWriteAddr), .csrWriteData(csrWriteData),
    .trapEnter(trapEnter), .trapCause(trapCause), .trapPc(trapPc), .trapReturn(trapReturn),
    .retireValid(retireValid), .retireRd(retireRd), .retireData(retireData),
    .redirectValid(redirectValid), .redirectPc(redirectPc)
  );

  regFile i_regFile (
    .clk(clk), .rstN(rstN), .r1Addr(r1Addr), .r1Data(r1Data),
    .wen(regWen), .wAddr(regAddr), .wData(regData)
  );

  csrFile i_csrFile (
    .clk(clk), .rstN(rstN), .readAddr(csrReadAddr), .readData(csrReadData),
    .csrWen(csrWen), .csrWriteAddr(csrWriteAddr), .csrWriteData(csrWriteData),
    .trapEnter(trapEnter), .trapCause(trapCause), .trapPc(trapPc), .trapReturn(trapReturn),
    .mtvec(mtvec), .mepc(mepc)
  );

endmodule

//--- logic/csrExecute.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrExecute (
  input  logic                   exValid,
  input  logic [2:0]             exOp,
  input  logic [`REG_ADDR_W-1:0] exRd,
  input  logic [`XLEN-1:0]       exRs1Val,
  input  logic [`XLEN-1:0]       exImm,
  input  csrPkg::csrAddrT        exCsrAddr,
  input  logic [`XLEN-1:0]       exCsrOld,
  input  logic [`XLEN-1:0]       exPc,
  input  logic [`XLEN-1:0]       mtvec,
  input  logic [`XLEN-1:0]       mepc,
  output logic                   regWen,
  output logic [`REG_ADDR_W-1:0] regAddr,
  output logic [`XLEN-1:0]       regData,
  output logic                   csrWen,
  output csrPkg::csrAddrT        csrWriteAddr,
  output logic [`XLEN-1:0]       csrWriteData,
  output logic                   trapEnter,
  output csrPkg::causeT          trapCause,
  output logic [`XLEN-1:0]       trapPc,
  output logic                   trapReturn,
  output logic                   retireValid,
  output logic [`REG_ADDR_W-1:0] retireRd,
  output logic [`XLEN-1:0]       retireData,
  output logic                   redirectValid,
  output logic [`XLEN-1:0]       redirectPc
);

  csrPkg::opT op;
  logic isCsr;
  logic isAddi;
  logic setClr;

  assign op = csrPkg::opT'(exOp);
  assign isAddi = (op == csrPkg::opAddi);
  assign isCsr = (op == csrPkg::opCsrrw) || (op == csrPkg::opCsrrs) || (op == csrPkg::opCsrrc);
  assign setClr = (op == csrPkg::opCsrrs) || (op == csrPkg::opCsrrc);

  // register writeback, rd = 0 still retires
  assign regWen = exValid && (isAddi || isCsr);
  assign regAddr = exRd;
  assign regData = isAddi ? (exRs1Val + exImm) : exCsrOld;

  // set/clear with a zero mask leaves the CSR alone
  assign csrWen = exValid && ((op == csrPkg::opCsrrw) || (setClr && (exRs1Val != '0)));
  assign csrWriteAddr = exCsrAddr;

  always_comb begin
    case (op)
      csrPkg::opCsrrs: csrWriteData = exCsrOld | exRs1Val;
      csrPkg::opCsrrc: csrWriteData = exCsrOld & ~exRs1Val;
      default: csrWriteData = exRs1Val;
    endcase
  end

  assign trapEnter = exValid && ((op == csrPkg::opEcall) || (op == csrPkg::opIllegal));
  assign trapCause = (op == csrPkg::opEcall) ? csrPkg::causeEcall : csrPkg::causeIllegal;
  assign trapPc = exPc;
  assign trapReturn = exValid && (op == csrPkg::opMret);

  assign retireValid = regWen;
  assign retireRd = regAddr;
  assign retireData = regData;

  // direct mode only, low mode bits ignored
  assign redirectValid = trapEnter || trapReturn;
  assign redirectPc = trapReturn ? mepc : {mtvec[`XLEN-1:2], 2'b00};

endmodule

//--- logic/csrFile.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module csrFile (
  input  logic                 clk,
  input  logic                 rstN,
  input  csrPkg::csrAddrT      readAddr,
  output logic [`XLEN-1:0]     readData,
  input  logic                 csrWen,
  input  csrPkg::csrAddrT      csrWriteAddr,
  input  logic [`XLEN-1:0]     csrWriteData,
  input  logic                 trapEnter,
  input  csrPkg::causeT        trapCause,
  input  logic [`XLEN-1:0]     trapPc,
  input  logic                 trapReturn,
  output logic [`XLEN-1:0]     mtvec,
  output logic [`XLEN-1:0]     mepc
);

  // mstatus bit positions
  localparam int MieBit = 3;
  localparam int MpieBit = 7;

  logic [`XLEN-1:0] mstatusQ;
  logic [`XLEN-1:0] mtvecQ;
  logic [`XLEN-1:0] mepcQ;
  logic [`XLEN-1:0] mcauseQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mstatusQ <= `MSTATUS_RESET;
      mtvecQ <= `MTVEC_RESET;
      mepcQ <= '0;
      mcauseQ <= '0;
    end else begin
      // software write, unknown addresses fall through
      if (csrWen) begin
        case (csrWriteAddr)
          csrPkg::csrMstatus: mstatusQ <= csrWriteData;
          csrPkg::csrMtvec: mtvecQ <= csrWriteData;
          csrPkg::csrMepc: mepcQ <= csrWriteData;
          csrPkg::csrMcause: mcauseQ <= csrWriteData;
          default: ;
        endcase
      end

      // trap entry saves state and masks interrupts
      if (trapEnter) begin
        mepcQ <= trapPc;
        mcauseQ <= trapCause;
        mstatusQ[MpieBit] <= mstatusQ[MieBit];
        mstatusQ[MieBit] <= 1'b0;
      end

      // mret restores the interrupt enable
      if (trapReturn) begin
        mstatusQ[MieBit] <= mstatusQ[MpieBit];
        mstatusQ[MpieBit] <= 1'b1;
      end
    end
  end

  always_comb begin
    case (readAddr)
      csrPkg::csrMstatus: readData = mstatusQ;
      csrPkg::csrMtvec: readData = mtvecQ;
      csrPkg::csrMepc: readData = mepcQ;
      csrPkg::csrMcause: readData = mcauseQ;
      default: readData = '0;
    endcase
  end

  assign mtvec = mtvecQ;
  assign mepc = mepcQ;

endmodule

//--- logic/csrPkg.sv
`include "csr_config.svh"

package csrPkg;

  typedef logic [11:0] csrAddrT;

  // implemented machine CSRs
  localparam csrAddrT csrMstatus = 12'h300;
  localparam csrAddrT csrMtvec = 12'h305;
  localparam csrAddrT csrMepc = 12'h341;
  localparam csrAddrT csrMcause = 12'h342;

  typedef enum logic [2:0] {
    opAddi,
    opCsrrw,
    opCsrrs,
    opCsrrc,
    opEcall,
    opMret,
    opIllegal
  } opT;

  typedef logic [`XLEN-1:0] causeT;

  // exception codes written to mcause
  localparam causeT causeEcall = 64'd11;
  localparam causeT causeIllegal = 64'd2;

endpackage

//--- logic/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// data path width
`define XLEN 64

// general register file geometry
`define NUM_REGS 32
`define REG_ADDR_W 5

// trap vector after reset
`define MTVEC_RESET 64'h0000_0000_8000_0100

// MPP = machine, MIE set, MPIE clear
`define MSTATUS_RESET 64'h0000_0000_0000_1808

`endif

//--- logic/instrDecode.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module instrDecode (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic [31:0]            instr,
  input  logic [`XLEN-1:0]       pc,
  output logic [`REG_ADDR_W-1:0] r1Addr,
  input  logic [`XLEN-1:0]       r1Data,
  output csrPkg::csrAddrT        csrReadAddr,
  input  logic [`XLEN-1:0]       csrReadData,
  input  logic                   fwdRegWen,
  input  logic [`REG_ADDR_W-1:0] fwdRegAddr,
  input  logic [`XLEN-1:0]       fwdRegData,
  input  logic                   fwdCsrWen,
  input  csrPkg::csrAddrT        fwdCsrAddr,
  input  logic [`XLEN-1:0]       fwdCsrData,
  output logic                   exValid,
  output csrPkg::opT             exOp,
  output logic [`REG_ADDR_W-1:0] exRd,
  output logic [`XLEN-1:0]       exRs1Val,
  output logic [`XLEN-1:0]       exImm,
  output csrPkg::csrAddrT        exCsrAddr,
  output logic [`XLEN-1:0]       exCsrOld,
  output logic [`XLEN-1:0]       exPc
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [`REG_ADDR_W-1:0] rdIdx;
  logic [`REG_ADDR_W-1:0] rs1Idx;
  logic [11:0] imm12;
  logic knownCsr;
  logic [`XLEN-1:0] rs1Val;
  logic [`XLEN-1:0] csrOld;
  csrPkg::opT op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rdIdx = instr[11:7];
  assign rs1Idx = instr[19:15];
  assign imm12 = instr[31:20];

  always_comb begin
    op = csrPkg::opIllegal;
    case (opcode)
      7'b0010011: if (funct3 == 3'b000) op = csrPkg::opAddi;
      7'b1110011: begin
        case (funct3)
          3'b000: begin
            if ((rdIdx == '0) && (rs1Idx == '0)) begin
              if (imm12 == 12'h000) op = csrPkg::opEcall;
              else if (imm12 == 12'h302) op = csrPkg::opMret;
            end
          end
          3'b001: op = csrPkg::opCsrrw;
          3'b010: op = csrPkg::opCsrrs;
          3'b011: op = csrPkg::opCsrrc;
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  assign r1Addr = rs1Idx;
  assign csrReadAddr = imm12;

  // a write to an unimplemented CSR must not be seen on read
  assign knownCsr = (imm12 == csrPkg::csrMstatus) || (imm12 == csrPkg::csrMtvec) ||
                    (imm12 == csrPkg::csrMepc) || (imm12 == csrPkg::csrMcause);

  // bypass from stage two writes in flight
  assign rs1Val = (fwdRegWen && (fwdRegAddr == rs1Idx) && (rs1Idx != '0)) ? fwdRegData : r1Data;
  assign csrOld = (fwdCsrWen && (fwdCsrAddr == imm12) && knownCsr) ? fwdCsrData : csrReadData;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exValid <= 1'b0;
    end else begin
      exValid <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      exOp <= op;
      exRd <= rdIdx;
      exRs1Val <= rs1Val;
      exImm <= {{(`XLEN-12){imm12[11]}}, imm12};
      exCsrAddr <= imm12;
      exCsrOld <= csrOld;
      exPc <= pc;
    end
  end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps
`include "csr_config.svh"

module regFile (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic [`REG_ADDR_W-1:0] r1Addr,
  output logic [`XLEN-1:0]       r1Data,
  input  logic                   wen,
  input  logic [`REG_ADDR_W-1:0] wAddr,
  input  logic [`XLEN-1:0]       wData
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 never gets written, so it stays zero after reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  assign r1Data = regs[r1Addr];

endmodule
